// ==== Makefile ====
SRCS := $(shell cat flist.f)

all: run

obj_dir/Vcsr_file_tb: flist.f $(SRCS)
	verilator --binary --assert -j 0 --top-module csr_file_tb -f flist.f

run: obj_dir/Vcsr_file_tb
	@out="$$(./obj_dir/Vcsr_file_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== flist.f ====
verilog/csr_pkg.sv
verilog/csr_trap_ctrl.sv
verilog/csr_int_ctrl.sv
verilog/csr_timer.sv
verilog/csr_scratch.sv
verilog/csr_read_sel.sv
verilog/csr_file.sv
sim/csr_file_chk.sv
sim/csr_file_tb.sv

// ==== sim/csr_file_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file_chk (
    input logic                  clk,
    input logic                  reset,
    input logic                  csr_we,
    input csr_pkg::csr_num_t     csr_num,
    input logic                  wb_ex,
    input csr_pkg::plv_t         crmd_plv,
    input logic                  has_int,
    input csr_pkg::csr_word_t    ex_entry,
    input csr_pkg::stable_cnt_t  counter
);
    import csr_pkg::*;

    // exception drops IE, nothing can be taken right after it
    ex_masks_int: assert property (@(posedge clk) disable iff (reset) wb_ex |=> !has_int)
        else $error("has_int high right after exception");

    ex_clears_plv: assert property (@(posedge clk) disable iff (reset) wb_ex |=> crmd_plv == 2'b0)
        else $error("CRMD.PLV not 0 after exception");

    entry_stable: assert property (@(posedge clk) disable iff (reset)
        !(csr_we && csr_num == CSR_EENTRY) |=> $stable(ex_entry))
        else $error("ex_entry changed without an EENTRY write");

    // first cycle out of reset has no valid history
    counter_steps: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> counter == $past(counter) + 64'd1)
        else $error("stable counter did not advance by one");

endmodule

bind csr_file csr_file_chk u_chk (
    .clk(clk), .reset(reset), .csr_we(csr_we), .csr_num(csr_num), .wb_ex(wb_ex),
    .crmd_plv(crmd_plv), .has_int(has_int), .ex_entry(ex_entry), .counter(counter)
);

`default_nettype wire

// ==== sim/csr_file_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;
    import csr_pkg::*;

    localparam int NUM_SAVE  = 4;
    localparam int K_MAX     = 6;  // largest timer INITVAL used
    localparam int RESET_LEN = 5;
    localparam int COUNT_GAP = 20;
    // cycles per test, in run order
    localparam int BUDGET = (RESET_LEN + COUNT_GAP + 5) + 60 + 20 + (4 * K_MAX + 20)
                          + (8 * K_MAX + 30) + 50;
    localparam int SLACK  = 200;

    logic         clk;
    logic         reset;
    logic         csr_we;
    csr_num_t     csr_num;
    csr_word_t    csr_wmask;
    csr_word_t    csr_wvalue;
    csr_word_t    csr_rvalue;
    logic         wb_ex;
    logic         ertn_flush;
    ecode_t       wb_ecode;
    esubcode_t    wb_esubcode;
    csr_word_t    wb_pc;
    csr_word_t    ex_entry;
    csr_word_t    ex_era;
    logic         has_int;
    stable_cnt_t  counter;
    csr_word_t    counter_id;

    int errors;
    int tests_run;
    int tests_failed;

    csr_file #(.NUM_SAVE(NUM_SAVE)) DUT (
        .clk(clk), .reset(reset), .csr_we(csr_we), .csr_num(csr_num),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue), .csr_rvalue(csr_rvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_ecode(wb_ecode),
        .wb_esubcode(wb_esubcode), .wb_pc(wb_pc), .ex_entry(ex_entry),
        .ex_era(ex_era), .has_int(has_int), .counter(counter), .counter_id(counter_id)
    );

    always #5 clk = ~clk;

    task automatic check_word(input csr_word_t got, input csr_word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input stable_cnt_t got, input stable_cnt_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one access cycle, returns on the falling edge after it lands
    task automatic csr_write(input csr_num_t num, input csr_word_t mask, input csr_word_t value);
        @(negedge clk);
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic read_back(input csr_num_t num, output csr_word_t value);
        csr_num = num;
        #1;
        value = csr_rvalue;
    endtask

    task automatic pulse_events(input logic ex, input logic ertn, input csr_word_t pc,
                                input ecode_t ec, input esubcode_t es);
        @(negedge clk);
        wb_ex       = ex;
        ertn_flush  = ertn;
        wb_pc       = pc;
        wb_ecode    = ec;
        wb_esubcode = es;
        @(negedge clk);
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic log_result(input string name, input int errors_at_start);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%-18s ok", name);
        end else begin
            tests_failed++;
            $display("%-18s %0d failed checks", name, errors - errors_at_start);
        end
    endtask

    task automatic reset_values();
        csr_word_t   rv;
        stable_cnt_t first;
        stable_cnt_t second;
        read_back(CSR_CRMD, rv);
        check_word(rv, 32'h0000_0008, "CRMD after reset");
        read_back(CSR_TVAL, rv);
        check_word(rv, 32'hffff_ffff, "TVAL after reset");
        check_bit(has_int, 1'b0, "has_int after reset");
        first = counter;
        repeat (COUNT_GAP) @(negedge clk);
        second = counter;
        check_count(second - first, stable_cnt_t'(COUNT_GAP), "stable counter step");
    endtask

    task automatic merge_check(input csr_num_t num, input csr_word_t writable, input string name,
                               output csr_word_t exp_val);
        csr_word_t val;
        csr_word_t mask;
        csr_word_t got;
        exp_val = '0; // all of these reset to zero
        for (int rep = 0; rep < 2; rep++) begin
            val  = $urandom;
            mask = $urandom;
            csr_write(num, mask, val);
            exp_val = ((exp_val & ~mask) | (val & mask)) & writable;
            read_back(num, got);
            check_word(got, exp_val, name);
        end
    endtask

    task automatic masked_writes();
        csr_word_t exp_word;
        csr_word_t rv;
        csr_num_t  holes [5];
        for (int i = 0; i < NUM_SAVE; i++)
            merge_check(CSR_SAVE0 + csr_num_t'(i), 32'hffff_ffff, $sformatf("SAVE%0d", i),
                        exp_word);
        merge_check(CSR_TID, 32'hffff_ffff, "TID", exp_word);
        check_word(counter_id, exp_word, "counter_id");
        merge_check(CSR_ECFG, 32'h0000_1fff, "ECFG", exp_word);
        merge_check(CSR_PRMD, 32'h0000_0007, "PRMD", exp_word);
        merge_check(CSR_EENTRY, 32'hffff_ffc0, "EENTRY", exp_word);
        check_word(ex_entry, exp_word, "ex_entry");
        holes = '{14'h2, 14'h3, 14'h2f, 14'h44, 14'h3fff}; // TICLR reads zero too
        foreach (holes[i]) begin
            @(negedge clk);
            read_back(holes[i], rv);
            check_word(rv, 32'h0, $sformatf("unmapped CSR %h", holes[i]));
        end
    endtask

    task automatic trap_entry_return();
        csr_word_t rv;
        csr_word_t pc;
        ecode_t    ec;
        esubcode_t es;
        pc = $urandom;
        ec = ecode_t'($urandom);
        es = esubcode_t'($urandom);
        csr_write(CSR_CRMD, 32'h7, 32'h7); // PLV 3, IE 1
        pulse_events(1'b1, 1'b0, pc, ec, es);
        read_back(CSR_CRMD, rv);
        check_word(rv & 32'h7, 32'h0, "CRMD PLV/IE after exception");
        read_back(CSR_PRMD, rv);
        check_word(rv, 32'h7, "PRMD saved context");
        read_back(CSR_ERA, rv);
        check_word(rv, pc, "ERA");
        check_word(ex_era, pc, "ex_era");
        read_back(CSR_ESTAT, rv);
        check_word(rv & 32'h7fff_0000, {1'b0, es, ec, 16'h0}, "ESTAT codes");
        pulse_events(1'b0, 1'b1, 32'h0, 6'h0, 9'h0);
        read_back(CSR_CRMD, rv);
        check_word(rv & 32'h7, 32'h7, "CRMD after ERTN");
        csr_write(CSR_CRMD, 32'h7, 32'h1); // PLV 1, IE 0
        pc = $urandom;
        pulse_events(1'b1, 1'b1, pc, ec, es); // exception wins
        read_back(CSR_CRMD, rv);
        check_word(rv & 32'h7, 32'h0, "CRMD with exception and ERTN");
        read_back(CSR_PRMD, rv);
        check_word(rv, 32'h1, "PRMD with exception and ERTN");
        read_back(CSR_ERA, rv);
        check_word(rv, pc, "ERA with exception and ERTN");
    endtask

    task automatic oneshot_timer();
        csr_word_t rv;
        csr_word_t start;
        int        k;
        int        j;
        k = $urandom_range(K_MAX, 1);
        j = $urandom_range(k, 1);
        start = csr_word_t'(4 * k);
        csr_write(CSR_TCFG, 32'hffff_ffff, start | 32'h1);
        read_back(CSR_TVAL, rv);
        check_word(rv, start, "TVAL load");
        repeat (j) @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, start - csr_word_t'(j), "TVAL count");
        repeat (4 * k - j) @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, 32'h0, "TVAL at zero");
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b0, "timer pending too early");
        @(negedge clk);
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b1, "timer pending");
        read_back(CSR_TVAL, rv);
        check_word(rv, 32'hffff_ffff, "TVAL stops at idle");
        repeat (3) @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, 32'hffff_ffff, "TVAL holds idle");
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b0, "TICLR clears pending");
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h0);
    endtask

    task automatic periodic_timer();
        csr_word_t rv;
        csr_word_t start;
        int        k;
        k = $urandom_range(K_MAX, 1);
        start = csr_word_t'(4 * k);
        csr_write(CSR_TCFG, 32'hffff_ffff, start | 32'h3);
        repeat (4 * k) @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, 32'h0, "TVAL at zero");
        @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, start, "TVAL first reload");
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b1, "first period pending");
        csr_write(CSR_TICLR, 32'h1, 32'h1); // two edges into the period
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b0, "pending cleared between periods");
        repeat (4 * k - 1) @(negedge clk);
        read_back(CSR_TVAL, rv);
        check_word(rv, start, "TVAL second reload");
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b1, "second period pending");
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h0);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
    endtask

    task automatic interrupt_gating();
        csr_word_t rv;
        csr_write(CSR_ECFG, 32'hffff_ffff, 32'h0);
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h5); // INITVAL 1, one-shot
        repeat (5) @(negedge clk);
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h0);
        read_back(CSR_ESTAT, rv);
        check_bit(rv[INT_TIMER], 1'b1, "timer pending for gating");
        for (int c = 0; c < 4; c++) begin
            csr_write(CSR_CRMD, 32'h4, {29'b0, c[1], 2'b0});
            csr_write(CSR_ECFG, 32'h800, {20'b0, c[0], 11'b0});
            check_bit(has_int, c[0] & c[1], $sformatf("has_int ie=%0d lie11=%0d", c[1], c[0]));
        end
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        check_bit(has_int, 1'b0, "has_int after TICLR");
        csr_write(CSR_ECFG, 32'h3, 32'h2);
        csr_write(CSR_ESTAT, 32'h3, 32'h2);
        check_bit(has_int, 1'b1, "has_int from software bit 1");
        read_back(CSR_ESTAT, rv);
        check_word(rv & 32'h1fff, 32'h2, "ESTAT.IS software bit");
        csr_write(CSR_ESTAT, 32'h3, 32'h0);
        check_bit(has_int, 1'b0, "has_int after software clear");
        csr_write(CSR_CRMD, 32'h4, 32'h0);
    endtask

    initial begin
        int start_errors;
        void'($urandom(32'h8c47_8e02));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clk          = 1'b0;
        reset        = 1'b1;
        csr_we       = 1'b0;
        csr_num      = '0;
        csr_wmask    = '0;
        csr_wvalue   = '0;
        wb_ex        = 1'b0;
        ertn_flush   = 1'b0;
        wb_ecode     = '0;
        wb_esubcode  = '0;
        wb_pc        = '0;
        repeat (RESET_LEN) @(negedge clk);
        reset = 1'b0;

        start_errors = errors;
        reset_values();
        log_result("reset_values", start_errors);
        start_errors = errors;
        masked_writes();
        log_result("masked_writes", start_errors);
        start_errors = errors;
        trap_entry_return();
        log_result("trap_entry_return", start_errors);
        start_errors = errors;
        oneshot_timer();
        log_result("oneshot_timer", start_errors);
        start_errors = errors;
        periodic_timer();
        log_result("periodic_timer", start_errors);
        start_errors = errors;
        interrupt_gating();
        log_result("interrupt_gating", start_errors);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial begin
        repeat (BUDGET + SLACK) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", BUDGET + SLACK);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter int NUM_SAVE = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_we,
    input  csr_pkg::csr_num_t     csr_num,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    output csr_pkg::csr_word_t    csr_rvalue,
    input  logic                  wb_ex,
    input  logic                  ertn_flush,
    input  csr_pkg::ecode_t       wb_ecode,
    input  csr_pkg::esubcode_t    wb_esubcode,
    input  csr_pkg::csr_word_t    wb_pc,
    output csr_pkg::csr_word_t    ex_entry,
    output csr_pkg::csr_word_t    ex_era,
    output logic                  has_int,
    output csr_pkg::stable_cnt_t  counter,
    output csr_pkg::csr_word_t    counter_id
);
    import csr_pkg::*;

    plv_t       crmd_plv;
    logic       crmd_ie;
    logic       crmd_da;
    logic       crmd_pg;
    logic [1:0] crmd_datf;
    logic [1:0] crmd_datm;
    plv_t       prmd_pplv;
    logic       prmd_pie;
    ecode_t     estat_ecode;
    esubcode_t  estat_esubcode;
    int_vec_t   ecfg_lie;
    int_vec_t   estat_is;
    logic       timer_int;
    csr_word_t  tcfg;
    timer_val_t tval;
    csr_word_t  save_data [NUM_SAVE];
    csr_word_t  tid;

    assign counter_id = tid;

    csr_trap_ctrl u_trap (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .wb_ecode, .wb_esubcode, .wb_pc,
        .crmd_plv, .crmd_ie, .crmd_da, .crmd_pg, .crmd_datf, .crmd_datm,
        .prmd_pplv, .prmd_pie, .estat_ecode, .estat_esubcode,
        .ex_era, .ex_entry
    );

    csr_int_ctrl u_int (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .crmd_ie, .timer_int, .ecfg_lie, .estat_is, .has_int
    );

    csr_timer u_timer (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .tcfg, .tval, .timer_int, .counter
    );

    csr_scratch #(.NUM_SAVE(NUM_SAVE)) u_scratch (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .save_data, .tid
    );

    csr_read_sel #(.NUM_SAVE(NUM_SAVE)) u_read_sel (
        .csr_num,
        .crmd_plv, .crmd_ie, .crmd_da, .crmd_pg, .crmd_datf, .crmd_datm,
        .prmd_pplv, .prmd_pie, .estat_ecode, .estat_esubcode,
        .ex_era, .ex_entry, .estat_is, .ecfg_lie, .tcfg, .tval,
        .save_data, .tid, .csr_rvalue
    );

endmodule

`default_nettype wire

// ==== verilog/csr_int_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_int_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_we,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    input  logic                crmd_ie,
    input  logic                timer_int,
    output csr_pkg::int_vec_t   ecfg_lie,
    output csr_pkg::int_vec_t   estat_is,
    output logic                has_int
);
    import csr_pkg::*;

    logic [1:0] swi; // software interrupts IS[1:0]

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            swi      <= '0;
        end else if (csr_we) begin
            if (csr_num == CSR_ECFG)
                ecfg_lie <= (csr_wvalue[ECFG_LIE +: 13] & csr_wmask[ECFG_LIE +: 13])
                          | (ecfg_lie & ~csr_wmask[ECFG_LIE +: 13]);
            if (csr_num == CSR_ESTAT)
                swi <= (csr_wvalue[ESTAT_IS +: 2] & csr_wmask[ESTAT_IS +: 2])
                     | (swi & ~csr_wmask[ESTAT_IS +: 2]);
        end
    end

    always_comb begin
        estat_is            = '0; // no hardware or ipi sources here
        estat_is[1:0]       = swi;
        estat_is[INT_TIMER] = timer_int;
    end

    assign has_int = crmd_ie && ((estat_is[11:0] & ecfg_lie[11:0]) != 12'b0);

endmodule

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [63:0] stable_cnt_t;
    typedef logic [31:0] timer_val_t;

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30; // SAVEn at SAVE0 + n
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // low bit of each field
    localparam int CRMD_PLV       = 0;  // 2 bits
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF      = 5;  // 2 bits
    localparam int CRMD_DATM      = 7;  // 2 bits
    localparam int PRMD_PPLV      = 0;  // 2 bits
    localparam int PRMD_PIE       = 2;
    localparam int ECFG_LIE       = 0;  // 13 bits
    localparam int ESTAT_IS       = 0;  // 13 bits
    localparam int ESTAT_ECODE    = 16; // 6 bits
    localparam int ESTAT_ESUBCODE = 22; // 9 bits
    localparam int EENTRY_VA      = 6;  // 26 bits
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL   = 2;  // 30 bits
    localparam int TICLR_CLR      = 0;
    localparam int INT_TIMER      = 11;

    localparam timer_val_t TIMER_IDLE = '1;

endpackage

`default_nettype wire

// ==== verilog/csr_read_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_read_sel #(
    parameter int NUM_SAVE = 4
) (
    input  csr_pkg::csr_num_t    csr_num,
    input  csr_pkg::plv_t        crmd_plv,
    input  logic                 crmd_ie,
    input  logic                 crmd_da,
    input  logic                 crmd_pg,
    input  logic [1:0]           crmd_datf,
    input  logic [1:0]           crmd_datm,
    input  csr_pkg::plv_t        prmd_pplv,
    input  logic                 prmd_pie,
    input  csr_pkg::ecode_t      estat_ecode,
    input  csr_pkg::esubcode_t   estat_esubcode,
    input  csr_pkg::csr_word_t   ex_era,
    input  csr_pkg::csr_word_t   ex_entry,
    input  csr_pkg::int_vec_t    estat_is,
    input  csr_pkg::int_vec_t    ecfg_lie,
    input  csr_pkg::csr_word_t   tcfg,
    input  csr_pkg::timer_val_t  tval,
    input  csr_pkg::csr_word_t   save_data [NUM_SAVE],
    input  csr_pkg::csr_word_t   tid,
    output csr_pkg::csr_word_t   csr_rvalue
);
    import csr_pkg::*;

    csr_word_t crmd_w;
    csr_word_t prmd_w;
    csr_word_t ecfg_w;
    csr_word_t estat_w;

    // reserved bits stay zero
    always_comb begin
        crmd_w                    = '0;
        crmd_w[CRMD_PLV +: 2]     = crmd_plv;
        crmd_w[CRMD_IE]           = crmd_ie;
        crmd_w[CRMD_DA]           = crmd_da;
        crmd_w[CRMD_PG]           = crmd_pg;
        crmd_w[CRMD_DATF +: 2]    = crmd_datf;
        crmd_w[CRMD_DATM +: 2]    = crmd_datm;
        prmd_w                    = '0;
        prmd_w[PRMD_PPLV +: 2]    = prmd_pplv;
        prmd_w[PRMD_PIE]          = prmd_pie;
        ecfg_w                    = '0;
        ecfg_w[ECFG_LIE +: 13]    = ecfg_lie;
        estat_w                   = '0;
        estat_w[ESTAT_IS +: 13]   = estat_is;
        estat_w[ESTAT_ECODE +: 6] = estat_ecode;
        estat_w[ESTAT_ESUBCODE +: 9] = estat_esubcode;
    end

    always_comb begin
        csr_rvalue = '0; // unmapped and TICLR read zero
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_w;
            CSR_PRMD:   csr_rvalue = prmd_w;
            CSR_ECFG:   csr_rvalue = ecfg_w;
            CSR_ESTAT:  csr_rvalue = estat_w;
            CSR_ERA:    csr_rvalue = ex_era;
            CSR_EENTRY: csr_rvalue = ex_entry;
            CSR_TID:    csr_rvalue = tid;
            CSR_TCFG:   csr_rvalue = tcfg;
            CSR_TVAL:   csr_rvalue = tval;
            default:    ;
        endcase
        for (int i = 0; i < NUM_SAVE; i++)
            if (csr_num == CSR_SAVE0 + csr_num_t'(i))
                csr_rvalue = save_data[i];
    end

endmodule

`default_nettype wire

// ==== verilog/csr_scratch.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_scratch #(
    parameter int NUM_SAVE = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_we,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    output csr_pkg::csr_word_t  save_data [NUM_SAVE],
    output csr_pkg::csr_word_t  tid
);
    import csr_pkg::*;

    csr_word_t wr_set;

    assign wr_set = csr_wvalue & csr_wmask;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SAVE; i++)
                save_data[i] <= '0;
            tid <= '0;
        end else if (csr_we) begin
            for (int i = 0; i < NUM_SAVE; i++)
                if (csr_num == CSR_SAVE0 + csr_num_t'(i))
                    save_data[i] <= wr_set | (save_data[i] & ~csr_wmask);
            if (csr_num == CSR_TID)
                tid <= wr_set | (tid & ~csr_wmask);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_we,
    input  csr_pkg::csr_num_t     csr_num,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    output csr_pkg::csr_word_t    tcfg,
    output csr_pkg::timer_val_t   tval,
    output logic                  timer_int,
    output csr_pkg::stable_cnt_t  counter
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   tcfg_next;
    logic        tcfg_sel;
    logic        ticlr_hit;
    logic        tval_zero;

    assign tcfg      = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_sel  = csr_we && csr_num == CSR_TCFG;
    assign tcfg_next = (csr_wvalue & csr_wmask) | (tcfg & ~csr_wmask); // tcfg after this write
    assign ticlr_hit = csr_we && csr_num == CSR_TICLR
                    && csr_wmask[TICLR_CLR] && csr_wvalue[TICLR_CLR];
    assign tval_zero = tcfg_en && tval == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_sel) begin
            tcfg_en       <= tcfg_next[TCFG_EN];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[TCFG_INITVAL +: 30];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tval <= TIMER_IDLE;
        else if (tcfg_sel && tcfg_next[TCFG_EN])
            tval <= {tcfg_next[TCFG_INITVAL +: 30], 2'b00}; // start
        else if (tval_zero)
            tval <= tcfg_periodic ? {tcfg_initval, 2'b00} : TIMER_IDLE;
        else if (tcfg_en && tval != TIMER_IDLE)
            tval <= tval - 32'd1;
    end

    // set wins over clear on the same edge
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (tval_zero)
            timer_int <= 1'b1;
        else if (ticlr_hit)
            timer_int <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            counter <= '0;
        else
            counter <= counter + 64'd1;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_we,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    input  logic                wb_ex,
    input  logic                ertn_flush,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    output csr_pkg::plv_t       crmd_plv,
    output logic                crmd_ie,
    output logic                crmd_da,
    output logic                crmd_pg,
    output logic [1:0]          crmd_datf,
    output logic [1:0]          crmd_datm,
    output csr_pkg::plv_t       prmd_pplv,
    output logic                prmd_pie,
    output csr_pkg::ecode_t     estat_ecode,
    output csr_pkg::esubcode_t  estat_esubcode,
    output csr_pkg::csr_word_t  ex_era,
    output csr_pkg::csr_word_t  ex_entry
);
    import csr_pkg::*;

    csr_word_t   wr_set;
    csr_word_t   wr_keep;
    logic        wr_en;
    logic [25:0] eentry_va;

    assign wr_set  = csr_wvalue & csr_wmask;
    assign wr_keep = ~csr_wmask;
    assign wr_en   = csr_we && !wb_ex && !ertn_flush; // events win over writes

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1; // direct addressing out of reset
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_en && csr_num == CSR_CRMD) begin
            crmd_plv  <= wr_set[CRMD_PLV +: 2] | (crmd_plv & wr_keep[CRMD_PLV +: 2]);
            crmd_ie   <= wr_set[CRMD_IE] | (crmd_ie & wr_keep[CRMD_IE]);
            crmd_da   <= wr_set[CRMD_DA] | (crmd_da & wr_keep[CRMD_DA]);
            crmd_pg   <= wr_set[CRMD_PG] | (crmd_pg & wr_keep[CRMD_PG]);
            crmd_datf <= wr_set[CRMD_DATF +: 2] | (crmd_datf & wr_keep[CRMD_DATF +: 2]);
            crmd_datm <= wr_set[CRMD_DATM +: 2] | (crmd_datm & wr_keep[CRMD_DATM +: 2]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            ex_era         <= '0;
            eentry_va      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            prmd_pplv      <= crmd_plv; // save context
            prmd_pie       <= crmd_ie;
            ex_era         <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (wr_en) begin
            if (csr_num == CSR_PRMD) begin
                prmd_pplv <= wr_set[PRMD_PPLV +: 2] | (prmd_pplv & wr_keep[PRMD_PPLV +: 2]);
                prmd_pie  <= wr_set[PRMD_PIE] | (prmd_pie & wr_keep[PRMD_PIE]);
            end
            if (csr_num == CSR_ERA)
                ex_era <= wr_set | (ex_era & wr_keep);
            if (csr_num == CSR_EENTRY)
                eentry_va <= wr_set[EENTRY_VA +: 26] | (eentry_va & wr_keep[EENTRY_VA +: 26]);
        end
    end

    assign ex_entry = {eentry_va, 6'b0}; // entry is 64-byte aligned

endmodule

`default_nettype wire
